/* design/issue_read_settings.svh */
// widths and counts for the issue stage; integer registers only, no fp or third operand
`ifndef ISSUE_READ_SETTINGS_SVH
`define ISSUE_READ_SETTINGS_SVH

// data path width of the integer pipeline
`define XLEN 64

// virtual address width, also the pc width
`define VLEN 39

// register index width and the number of architectural registers
`define REG_ADDR_SIZE 5
`define NR_REGS 32

// commit stage writes back through this many ports
`define NR_COMMIT_PORTS 2

// scoreboard tag width
`define TRANS_ID_BITS 3

`endif

/* design/issue_read_pkg.sv */
// shared types for issue_read; the enums hold only the integer units and ops the stage knows
`include "issue_read_settings.svh"

package issue_read_pkg;

  // ------------------------------------------------------------------
  // basic words
  // ------------------------------------------------------------------
  typedef logic [`XLEN-1:0]          xlen_t;
  typedef logic [`VLEN-1:0]          vaddr_t;
  typedef logic [`REG_ADDR_SIZE-1:0] reg_addr_t;
  typedef logic [`TRANS_ID_BITS-1:0] trans_id_t;

  // functional unit an instruction goes to
  // NONE means the decoder needs no unit at all
  typedef enum logic [2:0] {
    NONE,
    LOAD,
    STORE,
    ALU,
    CTRL_FLOW,
    MULT,
    CSR
  } fu_t;

  // operation code handed to the unit
  typedef enum logic [3:0] {
    ADD,
    SUB,
    ANDL,
    ORL,
    XORL,
    SLL,
    MUL,
    LD,
    SD,
    BEQ,
    CSR_RW,
    SFENCE_VMA
  } fu_op;

  // ------------------------------------------------------------------
  // decoded instruction as held in the scoreboard
  // ------------------------------------------------------------------
  typedef struct packed {
    vaddr_t    pc;
    trans_id_t trans_id;
    fu_t       fu;
    fu_op      op;
    reg_addr_t rs1;
    reg_addr_t rs2;
    reg_addr_t rd;
    // immediate value, later the result
    xlen_t     result;
    logic      use_imm;
    // rs1 field is an unsigned immediate
    logic      use_zimm;
    logic      use_pc;
    // exception already taken on this entry
    logic      ex_valid;
  } scoreboard_entry_t;

  // payload presented to the execute units
  typedef struct packed {
    fu_t       fu;
    fu_op      operation;
    xlen_t     operand_a;
    xlen_t     operand_b;
    xlen_t     imm;
    trans_id_t trans_id;
  } fu_data_t;

endpackage

/* design/issue_ctrl.sv */
// issue control: hazard, stall and ack are combinational; strobes are registered, one cycle
`timescale 1ns/1ns
`include "issue_read_settings.svh"

module issue_ctrl
  import issue_read_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              flush_i,
  input  logic                              stall_i,
  input  scoreboard_entry_t                 issue_instr_i,
  input  logic                              issue_instr_valid_i,
  input  fu_t       [`NR_REGS-1:0]          rd_clobber_i,
  input  logic                              rs1_valid_i,
  input  logic                              rs2_valid_i,
  input  logic                              flu_ready_i,
  input  logic                              lsu_ready_i,
  input  reg_addr_t [`NR_COMMIT_PORTS-1:0]  waddr_i,
  input  logic      [`NR_COMMIT_PORTS-1:0]  we_i,
  output logic                              issue_ack_o,
  output logic                              stall_issue_o,
  output logic                              forward_rs1_o,
  output logic                              forward_rs2_o,
  output logic                              alu_valid_o,
  output logic                              branch_valid_o,
  output logic                              lsu_valid_o,
  output logic                              mult_valid_o,
  output logic                              csr_valid_o
);

  logic stall;
  logic fu_busy;
  logic rd_free;
  logic rd_commit;
  logic accept;
  fu_t  rs1_clobber;
  fu_t  rs2_clobber;
  // csr writers cannot forward, except for an sfence
  logic csr_fwd_ok;

  logic alu_valid_q;
  logic branch_valid_q;
  logic lsu_valid_q;
  logic mult_valid_q;
  logic csr_valid_q;

  assign rs1_clobber = rd_clobber_i[issue_instr_i.rs1];
  assign rs2_clobber = rd_clobber_i[issue_instr_i.rs2];
  assign csr_fwd_ok  = (issue_instr_i.op == SFENCE_VMA);

  // ------------------------------------------------------------------
  // busy selection per unit
  // ------------------------------------------------------------------
  always_comb begin : unit_busy
    case (issue_instr_i.fu)
      ALU, CTRL_FLOW, CSR, MULT: fu_busy = ~flu_ready_i;
      LOAD, STORE:               fu_busy = ~lsu_ready_i;
      default:                   fu_busy = 1'b0;
    endcase
  end

  // ------------------------------------------------------------------
  // operand availability
  // ------------------------------------------------------------------
  always_comb begin : operand_check
    stall         = stall_i;
    forward_rs1_o = 1'b0;
    forward_rs2_o = 1'b0;
    // a zimm in rs1 is an immediate, nothing to wait for
    if (!issue_instr_i.use_zimm && (rs1_clobber != NONE)) begin
      if (rs1_valid_i && ((rs1_clobber != CSR) || csr_fwd_ok)) begin
        forward_rs1_o = 1'b1;
      end else begin
        stall = 1'b1;
      end
    end
    if (rs2_clobber != NONE) begin
      if (rs2_valid_i && ((rs2_clobber != CSR) || csr_fwd_ok)) begin
        forward_rs2_o = 1'b1;
      end else begin
        stall = 1'b1;
      end
    end
  end

  assign stall_issue_o = stall;

  // ------------------------------------------------------------------
  // waw check on rd, which a commit may release in this same cycle
  // ------------------------------------------------------------------
  assign rd_free = (rd_clobber_i[issue_instr_i.rd] == NONE);

  always_comb begin : rd_commit_check
    rd_commit = 1'b0;
    for (int unsigned i = 0; i < `NR_COMMIT_PORTS; i++) begin
      if (we_i[i] && (waddr_i[i] == issue_instr_i.rd)) begin
        rd_commit = 1'b1;
      end
    end
  end

  always_comb begin : issue_ack
    issue_ack_o = 1'b0;
    if (issue_instr_valid_i) begin
      if (!stall && !fu_busy && (rd_free || rd_commit)) begin
        issue_ack_o = 1'b1;
      end
      // exceptions and unit-less entries leave without conditions
      if (issue_instr_i.ex_valid || (issue_instr_i.fu == NONE)) begin
        issue_ack_o = 1'b1;
      end
    end
    // fixed latency result bus is taken by the multiplier next cycle
    if (mult_valid_q && (issue_instr_i.fu inside {ALU, CTRL_FLOW, CSR})) begin
      issue_ack_o = 1'b0;
    end
  end

  assign accept = issue_instr_valid_i && issue_ack_o && !issue_instr_i.ex_valid;

  // ------------------------------------------------------------------
  // per-unit strobes, one cycle after acceptance
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      alu_valid_q    <= 1'b0;
      branch_valid_q <= 1'b0;
      lsu_valid_q    <= 1'b0;
      mult_valid_q   <= 1'b0;
      csr_valid_q    <= 1'b0;
    end else begin
      // flush drops whatever would have been started
      alu_valid_q    <= !flush_i && accept && (issue_instr_i.fu == ALU);
      branch_valid_q <= !flush_i && accept && (issue_instr_i.fu == CTRL_FLOW);
      lsu_valid_q    <= !flush_i && accept && (issue_instr_i.fu inside {LOAD, STORE});
      mult_valid_q   <= !flush_i && accept && (issue_instr_i.fu == MULT);
      csr_valid_q    <= !flush_i && accept && (issue_instr_i.fu == CSR);
    end
  end

  assign alu_valid_o    = alu_valid_q;
  assign branch_valid_o = branch_valid_q;
  assign lsu_valid_o    = lsu_valid_q;
  assign mult_valid_o   = mult_valid_q;
  assign csr_valid_o    = csr_valid_q;

endmodule

/* design/gpr_regfile.sv */
// integer register file; reads are combinational, x0 reads zero, highest commit port wins
`timescale 1ns/1ns
`include "issue_read_settings.svh"

module gpr_regfile
  import issue_read_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  reg_addr_t                         raddr_a_i,
  input  reg_addr_t                         raddr_b_i,
  output xlen_t                             rdata_a_o,
  output xlen_t                             rdata_b_o,
  input  reg_addr_t [`NR_COMMIT_PORTS-1:0]  waddr_i,
  input  xlen_t     [`NR_COMMIT_PORTS-1:0]  wdata_i,
  input  logic      [`NR_COMMIT_PORTS-1:0]  we_i
);

  xlen_t mem_q [`NR_REGS];

  // ------------------------------------------------------------------
  // write ports
  // ------------------------------------------------------------------
  // later ports override earlier ones through the nonblocking order
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned r = 0; r < `NR_REGS; r++) begin
        mem_q[r] <= '0;
      end
    end else begin
      for (int unsigned i = 0; i < `NR_COMMIT_PORTS; i++) begin
        // x0 is hardwired, writes to it are dropped
        if (we_i[i] && (waddr_i[i] != '0)) begin
          mem_q[waddr_i[i]] <= wdata_i[i];
        end
      end
    end
  end

  // ------------------------------------------------------------------
  // read ports
  // ------------------------------------------------------------------
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : mem_q[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : mem_q[raddr_b_i];

endmodule

/* design/operand_select.sv */
// next-operand mux; later rules override earlier ones, store and branch keep rs2 as operand b
`timescale 1ns/1ns
`include "issue_read_settings.svh"

module operand_select
  import issue_read_pkg::*;
(
  input  scoreboard_entry_t issue_instr_i,
  input  logic              forward_rs1_i,
  input  logic              forward_rs2_i,
  // values from the scoreboard lookup
  input  xlen_t             rs1_i,
  input  xlen_t             rs2_i,
  // values from the register file
  input  xlen_t             rdata_a_i,
  input  xlen_t             rdata_b_i,
  output xlen_t             operand_a_o,
  output xlen_t             operand_b_o,
  output xlen_t             imm_o
);

  xlen_t pc_ext;
  xlen_t zimm_ext;
  logic  imm_to_b;

  // pc sign extended to the data width
  assign pc_ext = {{(`XLEN - `VLEN){issue_instr_i.pc[`VLEN-1]}}, issue_instr_i.pc};

  // zimm lives in the rs1 field, zero extended
  assign zimm_ext = {{(`XLEN - `REG_ADDR_SIZE){1'b0}}, issue_instr_i.rs1};

  // stores need rs2 as data and branches compare rs2, imm goes via imm_o there
  assign imm_to_b = issue_instr_i.use_imm
                  && (issue_instr_i.fu != STORE)
                  && (issue_instr_i.fu != CTRL_FLOW);

  // ------------------------------------------------------------------
  // operand a
  // ------------------------------------------------------------------
  always_comb begin : sel_operand_a
    operand_a_o = rdata_a_i;
    if (forward_rs1_i) begin
      operand_a_o = rs1_i;
    end
    if (issue_instr_i.use_pc) begin
      operand_a_o = pc_ext;
    end
    if (issue_instr_i.use_zimm) begin
      operand_a_o = zimm_ext;
    end
  end

  // ------------------------------------------------------------------
  // operand b
  // ------------------------------------------------------------------
  always_comb begin : sel_operand_b
    operand_b_o = rdata_b_i;
    if (forward_rs2_i) begin
      operand_b_o = rs2_i;
    end
    if (imm_to_b) begin
      operand_b_o = issue_instr_i.result;
    end
  end

  // immediate always travels on its own
  assign imm_o = issue_instr_i.result;

endmodule

/* design/id_ex_regs.sv */
// id/ex boundary register; reloads every cycle, no enable, so the unit must sample on its strobe
`timescale 1ns/1ns

module id_ex_regs
  import issue_read_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  scoreboard_entry_t issue_instr_i,
  input  xlen_t             operand_a_i,
  input  xlen_t             operand_b_i,
  input  xlen_t             imm_i,
  output fu_data_t          fu_data_o,
  output vaddr_t            pc_o
);

  // ------------------------------------------------------------------
  // payload flops
  // ------------------------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // idle payload, no unit selected
      fu_data_o.fu        <= NONE;
      fu_data_o.operation <= ADD;
      fu_data_o.operand_a <= '0;
      fu_data_o.operand_b <= '0;
      fu_data_o.imm       <= '0;
      fu_data_o.trans_id  <= '0;
      pc_o                <= '0;
    end else begin
      fu_data_o.fu        <= issue_instr_i.fu;
      fu_data_o.operation <= issue_instr_i.op;
      fu_data_o.operand_a <= operand_a_i;
      fu_data_o.operand_b <= operand_b_i;
      fu_data_o.imm       <= imm_i;
      // tag goes back to the scoreboard with the result
      fu_data_o.trans_id  <= issue_instr_i.trans_id;
      pc_o                <= issue_instr_i.pc;
    end
  end

endmodule

/* design/issue_read.sv */
// issue and operand-read stage; scoreboard lookups for rs1/rs2 must answer in the same cycle
`timescale 1ns/1ns
`include "issue_read_settings.svh"

module issue_read
  import issue_read_pkg::*;
(
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              flush_i,
  input  logic                              stall_i,
  // from the decoder / scoreboard
  input  scoreboard_entry_t                 issue_instr_i,
  input  logic                              issue_instr_valid_i,
  output logic                              issue_ack_o,
  // scoreboard operand lookup
  output reg_addr_t                         rs1_o,
  output reg_addr_t                         rs2_o,
  input  xlen_t                             rs1_i,
  input  xlen_t                             rs2_i,
  input  logic                              rs1_valid_i,
  input  logic                              rs2_valid_i,
  input  fu_t       [`NR_REGS-1:0]          rd_clobber_i,
  // execute unit readiness
  input  logic                              flu_ready_i,
  input  logic                              lsu_ready_i,
  // commit write back
  input  reg_addr_t [`NR_COMMIT_PORTS-1:0]  waddr_i,
  input  xlen_t     [`NR_COMMIT_PORTS-1:0]  wdata_i,
  input  logic      [`NR_COMMIT_PORTS-1:0]  we_i,
  // to the execute stage
  output fu_data_t                          fu_data_o,
  output vaddr_t                            pc_o,
  output logic                              alu_valid_o,
  output logic                              branch_valid_o,
  output logic                              lsu_valid_o,
  output logic                              mult_valid_o,
  output logic                              csr_valid_o,
  output logic                              stall_issue_o
);

  logic  forward_rs1;
  logic  forward_rs2;
  xlen_t rdata_a;
  xlen_t rdata_b;
  xlen_t operand_a_n;
  xlen_t operand_b_n;
  xlen_t imm_n;

  // scoreboard is polled with the raw source fields
  assign rs1_o = issue_instr_i.rs1;
  assign rs2_o = issue_instr_i.rs2;

  // ------------------------------------------------------------------
  // hazard, ack and strobes
  // ------------------------------------------------------------------
  issue_ctrl i_issue_ctrl (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .flush_i             (flush_i),
    .stall_i             (stall_i),
    .issue_instr_i       (issue_instr_i),
    .issue_instr_valid_i (issue_instr_valid_i),
    .rd_clobber_i        (rd_clobber_i),
    .rs1_valid_i         (rs1_valid_i),
    .rs2_valid_i         (rs2_valid_i),
    .flu_ready_i         (flu_ready_i),
    .lsu_ready_i         (lsu_ready_i),
    .waddr_i             (waddr_i),
    .we_i                (we_i),
    .issue_ack_o         (issue_ack_o),
    .stall_issue_o       (stall_issue_o),
    .forward_rs1_o       (forward_rs1),
    .forward_rs2_o       (forward_rs2),
    .alu_valid_o         (alu_valid_o),
    .branch_valid_o      (branch_valid_o),
    .lsu_valid_o         (lsu_valid_o),
    .mult_valid_o        (mult_valid_o),
    .csr_valid_o         (csr_valid_o)
  );

  // ------------------------------------------------------------------
  // register file and operand mux
  // ------------------------------------------------------------------
  gpr_regfile i_gpr_regfile (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .raddr_a_i (issue_instr_i.rs1),
    .raddr_b_i (issue_instr_i.rs2),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .waddr_i   (waddr_i),
    .wdata_i   (wdata_i),
    .we_i      (we_i)
  );

  operand_select i_operand_select (
    .issue_instr_i (issue_instr_i),
    .forward_rs1_i (forward_rs1),
    .forward_rs2_i (forward_rs2),
    .rs1_i         (rs1_i),
    .rs2_i         (rs2_i),
    .rdata_a_i     (rdata_a),
    .rdata_b_i     (rdata_b),
    .operand_a_o   (operand_a_n),
    .operand_b_o   (operand_b_n),
    .imm_o         (imm_n)
  );

  // id/ex boundary
  id_ex_regs i_id_ex_regs (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .issue_instr_i (issue_instr_i),
    .operand_a_i   (operand_a_n),
    .operand_b_i   (operand_b_n),
    .imm_i         (imm_n),
    .fu_data_o     (fu_data_o),
    .pc_o          (pc_o)
  );

endmodule

/* dv/tb_issue_read.sv */
// random testbench, fixed seed; the entry is held until acked, commit writes land one cycle later
`timescale 1ns/1ns
`include "issue_read_settings.svh"

module tb_issue_read
  import issue_read_pkg::*;
();

  localparam int unsigned SEED        = 32'hfe25;
  localparam int unsigned N_CYCLES    = 1500;
  localparam int unsigned CLK_PERIOD  = 100;
  localparam int unsigned DRIVE_DELAY = 10;
  // test cycles plus reset and a drain margin
  localparam int unsigned TIMEOUT     = (N_CYCLES + 3 + 20) * CLK_PERIOD;

  // expected response of one cycle
  typedef struct packed {
    logic     ack;
    logic     stall;
    fu_t      strobe;
    fu_data_t data;
    vaddr_t   pc;
  } expect_t;

  logic                             clk;
  logic                             rst_n;
  logic                             flush;
  logic                             stall_in;
  scoreboard_entry_t                instr;
  logic                             instr_valid;
  logic                             issue_ack;
  reg_addr_t                        rs1_addr;
  reg_addr_t                        rs2_addr;
  xlen_t                            rs1_val;
  xlen_t                            rs2_val;
  logic                             rs1_vld;
  logic                             rs2_vld;
  fu_t       [`NR_REGS-1:0]         clobber;
  logic                             flu_ready;
  logic                             lsu_ready;
  reg_addr_t [`NR_COMMIT_PORTS-1:0] waddr;
  xlen_t     [`NR_COMMIT_PORTS-1:0] wdata;
  logic      [`NR_COMMIT_PORTS-1:0] we;
  fu_data_t                         fu_data;
  vaddr_t                           pc;
  logic                             alu_valid;
  logic                             branch_valid;
  logic                             lsu_valid;
  logic                             mult_valid;
  logic                             csr_valid;
  logic                             stall_issue;

  // register contents as the testbench expects them
  xlen_t       mirror [`NR_REGS];
  expect_t     exp_q;
  logic        accepted_q;
  // decoder may present a new entry
  logic        taken;
  int unsigned errors;
  int unsigned checks;

  issue_read issue_read_i (
    .clk_i               (clk),
    .rst_ni              (rst_n),
    .flush_i             (flush),
    .stall_i             (stall_in),
    .issue_instr_i       (instr),
    .issue_instr_valid_i (instr_valid),
    .issue_ack_o         (issue_ack),
    .rs1_o               (rs1_addr),
    .rs2_o               (rs2_addr),
    .rs1_i               (rs1_val),
    .rs2_i               (rs2_val),
    .rs1_valid_i         (rs1_vld),
    .rs2_valid_i         (rs2_vld),
    .rd_clobber_i        (clobber),
    .flu_ready_i         (flu_ready),
    .lsu_ready_i         (lsu_ready),
    .waddr_i             (waddr),
    .wdata_i             (wdata),
    .we_i                (we),
    .fu_data_o           (fu_data),
    .pc_o                (pc),
    .alu_valid_o         (alu_valid),
    .branch_valid_o      (branch_valid),
    .lsu_valid_o         (lsu_valid),
    .mult_valid_o        (mult_valid),
    .csr_valid_o         (csr_valid),
    .stall_issue_o       (stall_issue)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ----------------------------------------------------------------------
  // stimulus helpers
  // ----------------------------------------------------------------------
  // small indices half the time, so hazards and x0 come up often
  function automatic reg_addr_t random_reg();
    if ($urandom_range(1) == 0) begin
      return reg_addr_t'($urandom_range(7));
    end
    return reg_addr_t'($urandom_range(31));
  endfunction

  function automatic scoreboard_entry_t random_entry();
    scoreboard_entry_t e;
    e.pc       = vaddr_t'({$urandom, $urandom});
    e.trans_id = trans_id_t'($urandom);
    e.fu       = fu_t'($urandom_range(6));
    e.op       = ($urandom_range(3) == 0) ? SFENCE_VMA : fu_op'($urandom_range(10));
    e.rs1      = random_reg();
    e.rs2      = random_reg();
    e.rd       = random_reg();
    e.result   = {$urandom, $urandom};
    e.use_imm  = ($urandom_range(1) == 0);
    e.use_zimm = ($urandom_range(5) == 0);
    e.use_pc   = ($urandom_range(5) == 0);
    e.ex_valid = ($urandom_range(15) == 0);
    return e;
  endfunction

  task automatic drive_idle();
    instr       = '0;
    instr_valid = 1'b0;
    flush       = 1'b0;
    stall_in    = 1'b0;
    rs1_val     = '0;
    rs2_val     = '0;
    rs1_vld     = 1'b0;
    rs2_vld     = 1'b0;
    clobber     = '0;
    flu_ready   = 1'b1;
    lsu_ready   = 1'b1;
    waddr       = '0;
    wdata       = '0;
    we          = '0;
  endtask

  task automatic drive_random();
    // an entry that was not taken stays in front of the stage
    if (taken) begin
      instr = random_entry();
    end
    instr_valid = ($urandom_range(7) != 0);
    stall_in    = ($urandom_range(15) == 0);
    flush       = ($urandom_range(11) == 0);
    flu_ready   = ($urandom_range(7) != 0);
    lsu_ready   = ($urandom_range(7) != 0);
    rs1_val     = {$urandom, $urandom};
    rs2_val     = {$urandom, $urandom};
    rs1_vld     = ($urandom_range(3) != 0);
    rs2_vld     = ($urandom_range(3) != 0);
    for (int r = 0; r < `NR_REGS; r++) begin
      clobber[r] = ($urandom_range(5) == 0) ? fu_t'($urandom_range(6, 1)) : NONE;
    end
    for (int i = 0; i < `NR_COMMIT_PORTS; i++) begin
      we[i]    = ($urandom_range(1) == 1);
      waddr[i] = random_reg();
      wdata[i] = {$urandom, $urandom};
    end
    // both ports on one register
    if ($urandom_range(3) == 0) begin
      waddr[1] = waddr[0];
    end
    // commit that frees the entry's rd
    if ($urandom_range(3) == 0) begin
      waddr[0] = instr.rd;
    end
  endtask

  // later port lands last and wins
  task automatic apply_commits();
    for (int i = 0; i < `NR_COMMIT_PORTS; i++) begin
      if (we[i] && (waddr[i] != '0)) begin
        mirror[waddr[i]] = wdata[i];
      end
    end
  endtask

  // ----------------------------------------------------------------------
  // reference model
  // ----------------------------------------------------------------------
  function automatic expect_t predict(input logic mult_prev);
    expect_t e;
    fu_t     c1;
    fu_t     c2;
    logic    fwd1;
    logic    fwd2;
    logic    csr_ok;
    logic    busy;
    logic    rd_ok;
    logic    accept;
    e      = '0;
    c1     = clobber[instr.rs1];
    c2     = clobber[instr.rs2];
    csr_ok = (instr.op == SFENCE_VMA);
    fwd1   = 1'b0;
    fwd2   = 1'b0;
    e.stall = stall_in;
    // zimm in rs1 is no register at all
    if (!instr.use_zimm && (c1 != NONE)) begin
      if (rs1_vld && ((c1 != CSR) || csr_ok)) begin
        fwd1 = 1'b1;
      end else begin
        e.stall = 1'b1;
      end
    end
    if (c2 != NONE) begin
      if (rs2_vld && ((c2 != CSR) || csr_ok)) begin
        fwd2 = 1'b1;
      end else begin
        e.stall = 1'b1;
      end
    end
    case (instr.fu)
      LOAD, STORE: busy = !lsu_ready;
      NONE:        busy = 1'b0;
      default:     busy = !flu_ready;
    endcase
    // rd counts as free when a commit port writes it this same cycle
    rd_ok = (clobber[instr.rd] == NONE);
    for (int i = 0; i < `NR_COMMIT_PORTS; i++) begin
      if (we[i] && (waddr[i] == instr.rd)) begin
        rd_ok = 1'b1;
      end
    end
    e.ack = instr_valid && ((!e.stall && !busy && rd_ok) || instr.ex_valid || (instr.fu == NONE));
    // shared result bus is busy right after a multiply
    if (mult_prev && (instr.fu inside {ALU, CTRL_FLOW, CSR})) begin
      e.ack = 1'b0;
    end
    accept   = instr_valid && e.ack && !instr.ex_valid;
    e.strobe = (accept && !flush) ? instr.fu : NONE;
    e.data.fu        = instr.fu;
    e.data.operation = instr.op;
    e.data.trans_id  = instr.trans_id;
    e.data.imm       = instr.result;
    e.data.operand_a = (instr.rs1 == '0) ? '0 : mirror[instr.rs1];
    if (fwd1) begin
      e.data.operand_a = rs1_val;
    end
    // pc sign extended to the data width
    if (instr.use_pc) begin
      e.data.operand_a = $signed(instr.pc);
    end
    if (instr.use_zimm) begin
      e.data.operand_a = xlen_t'(instr.rs1);
    end
    e.data.operand_b = (instr.rs2 == '0) ? '0 : mirror[instr.rs2];
    if (fwd2) begin
      e.data.operand_b = rs2_val;
    end
    if (instr.use_imm && (instr.fu != STORE) && (instr.fu != CTRL_FLOW)) begin
      e.data.operand_b = instr.result;
    end
    e.pc = instr.pc;
    return e;
  endfunction

  // ----------------------------------------------------------------------
  // compare tasks
  // ----------------------------------------------------------------------
  task automatic check_ack(input logic exp_ack, input logic exp_stall);
    checks++;
    if ((issue_ack !== exp_ack) || (stall_issue !== exp_stall)) begin
      errors++;
      $display("mismatch at %0t ns: ack/stall expected %b/%b got %b/%b",
               $time, exp_ack, exp_stall, issue_ack, stall_issue);
    end
  endtask

  task automatic check_lookup(input reg_addr_t exp_rs1, input reg_addr_t exp_rs2);
    checks++;
    if ((rs1_addr !== exp_rs1) || (rs2_addr !== exp_rs2)) begin
      errors++;
      $display("mismatch at %0t ns: rs1/rs2 lookup expected %0d/%0d got %0d/%0d",
               $time, exp_rs1, exp_rs2, rs1_addr, rs2_addr);
    end
  endtask

  task automatic check_strobes(input fu_t exp);
    logic [4:0] want;
    logic [4:0] got;
    want = {exp == ALU, exp == CTRL_FLOW, exp inside {LOAD, STORE}, exp == MULT, exp == CSR};
    got  = {alu_valid, branch_valid, lsu_valid, mult_valid, csr_valid};
    checks++;
    if (got !== want) begin
      errors++;
      $display("mismatch at %0t ns: strobes alu/br/lsu/mul/csr expected %b got %b",
               $time, want, got);
    end
  endtask

  task automatic check_fu_data(input fu_data_t exp);
    checks++;
    if (fu_data !== exp) begin
      errors++;
      $display("mismatch at %0t ns: fu_data expected %h got %h", $time, exp, fu_data);
    end
  endtask

  task automatic check_pc(input vaddr_t exp);
    checks++;
    if (pc !== exp) begin
      errors++;
      $display("mismatch at %0t ns: pc expected %h got %h", $time, exp, pc);
    end
  endtask

  // ----------------------------------------------------------------------
  // processes
  // ----------------------------------------------------------------------
  // inputs settle at +10, registered outputs at the edge, so the falling edge is quiet
  initial begin : compare
    expect_t e;
    // first pass sees the reset payload, NONE and ADD with zeros
    exp_q      = '0;
    accepted_q = 1'b1;
    taken      = 1'b1;
    @(posedge rst_n);
    forever begin
      @(negedge clk);
      check_strobes(exp_q.strobe);
      if (accepted_q) begin
        check_fu_data(exp_q.data);
        check_pc(exp_q.pc);
      end
      check_lookup(instr.rs1, instr.rs2);
      e = predict(exp_q.strobe == MULT);
      check_ack(e.ack, e.stall);
      accepted_q = instr_valid && e.ack;
      taken      = accepted_q || !instr_valid;
      exp_q      = e;
      apply_commits();
    end
  end

  initial begin : watchdog
    #(TIMEOUT);
    $display("watchdog: the run did not finish within its time limit");
    $display("Simulation failed");
    $finish;
  end

  initial begin : stimulus
    void'($urandom(SEED));
    errors   = 0;
    checks   = 0;
    for (int r = 0; r < `NR_REGS; r++) begin
      mirror[r] = '0;
    end
    clk   = 1'b0;
    rst_n = 1'b0;
    drive_idle();
    repeat (3) @(posedge clk);
    #(DRIVE_DELAY);
    rst_n = 1'b1;
    for (int unsigned n = 0; n < N_CYCLES; n++) begin
      @(posedge clk);
      #(DRIVE_DELAY);
      drive_random();
    end
    @(posedge clk);
    #(DRIVE_DELAY);
    drive_idle();
    // let the last accepted entry reach the compare
    repeat (2) @(negedge clk);
    #1;
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* issue_read.f */
+incdir+design
design/issue_read_pkg.sv
design/issue_ctrl.sv
design/gpr_regfile.sv
design/operand_select.sv
design/id_ex_regs.sv
design/issue_read.sv
dv/tb_issue_read.sv

/* Bender.yml */
package:
  name: issue_read

export_include_dirs:
  - design

sources:
  # package first, then the leaf modules, then the top level
  - files:
      - design/issue_read_pkg.sv
      - design/issue_ctrl.sv
      - design/gpr_regfile.sv
      - design/operand_select.sv
      - design/id_ex_regs.sv
      - design/issue_read.sv

  - target: test
    files:
      - dv/tb_issue_read.sv
